//--- Makefile
SIM = obj_dir/cpuSim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
		-f sources.f -o cpuSim
	./$(SIM) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

//--- common/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

  typedef logic [`CPU_WORD_W-1:0]    cpuWord;   // Register or memory value
  typedef logic [`CPU_WORD_W-1:0]    cpuAddr;   // Byte address
  typedef logic [`CPU_REG_IDX_W-1:0] regIndex;
  typedef logic [`CPU_OP_W-1:0]      opCode;

  // Instruction sequencer in execUnit
  typedef enum logic [2:0] {
    seqFetch,      // Instruction and data word from memory
    seqDecode,     // Operand read
    seqMemory,     // LD and ST only
    seqWriteback,  // Register write and ipointer update
    seqHalted      // After STALL
  } seqState;

endpackage

//--- common/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths
`define CPU_WORD_W     32
`define CPU_OP_W       8     // Opcode byte
`define CPU_REG_IDX_W  4     // Only the low 4 bits of a register field count
`define CPU_NUM_REGS   16

// Instruction pointer steps in bytes
`define CPU_SHORT_LEN  32'd4
`define CPU_LONG_LEN   32'd8  // Instruction word plus data word

// Opcodes in byte 0 of the instruction word
`define OP_MOV_RC      8'd1   // rA = const
`define OP_MOV_RR      8'd2   // rA = rB
`define OP_LD_RRO      8'd3   // rA = mem[rB + const]
`define OP_ST_RRO      8'd4   // mem[rA + const] = rB
`define OP_ADD_RRR     8'd5
`define OP_ADD_RRC     8'd6
`define OP_SUB_RRR     8'd7
`define OP_SHL_RRR     8'd8
`define OP_SHR_RRR     8'd9

// Compares write 0 or 1 into rA
`define OP_CMPLT_RRR   8'd10  // Unsigned
`define OP_CMPE_RRR    8'd11

// Control flow, target in the data word
`define OP_JMP_C       8'd12
`define OP_JZ_RC       8'd13  // Tests rC
`define OP_JNZ_RC      8'd14  // Tests rC
`define OP_STALL       8'd15  // Halts until reset

`endif

//--- core/execUnit.sv
`include "cpu_consts.svh"

module execUnit import cpuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  output logic   halted,
  output cpuAddr ipointer,
  // Fetch side
  output logic   fetchStart,
  output cpuAddr fetchAddr,
  output logic   needLong,
  input  logic   instrReady,
  input  logic   fetchDone,
  input  cpuWord instrWord,
  input  cpuWord dataWord,
  // Load/store side
  output logic   lsStart,
  output logic   lsWrite,
  output cpuWord baseValue,
  output cpuWord offsetValue,
  output cpuWord storeValue,
  input  logic   lsDone,
  input  cpuWord loadValue
);

  seqState state;
  logic    fetchBusy;                   // Fetch issued, waiting on fetchDone
  cpuWord  regFile [`CPU_NUM_REGS];
  cpuWord  valA;                        // Operands latched in decode
  cpuWord  valB;
  cpuWord  valC;
  opCode   op;
  regIndex rA;
  regIndex rB;
  regIndex rC;
  logic    isLong;
  logic    isMem;
  logic    doWrite;                     // Result goes to rA
  logic    takeJump;
  cpuWord  aluResult;
  cpuAddr  nextIp;

  function automatic logic longOp(opCode code);
    case (code)
      `OP_MOV_RC, `OP_LD_RRO, `OP_ST_RRO, `OP_ADD_RRC,
      `OP_JMP_C, `OP_JZ_RC, `OP_JNZ_RC: longOp = 1'b1;
      default: longOp = 1'b0;           // Unknown opcodes count as short
    endcase
  endfunction

  // Field decode straight off the held instruction word
  assign op     = instrWord[7:0];
  assign rA     = instrWord[11:8];
  assign rB     = instrWord[19:16];
  assign rC     = instrWord[27:24];
  assign isLong = longOp(op);
  assign isMem  = (op == `OP_LD_RRO) || (op == `OP_ST_RRO);

  assign needLong  = instrReady && isLong;
  assign fetchAddr = ipointer;
  assign halted    = (state == seqHalted);

  // Memory step
  assign lsWrite     = (op == `OP_ST_RRO);
  assign baseValue   = lsWrite ? valA : valB;   // ST is based on rA, LD on rB
  assign offsetValue = dataWord;
  assign storeValue  = valB;

  // ALU and writeback select
  always_comb begin
    aluResult = '0;
    doWrite   = 1'b1;
    case (op)
      `OP_MOV_RC:    aluResult = dataWord;
      `OP_MOV_RR:    aluResult = valB;
      `OP_LD_RRO:    aluResult = loadValue;
      `OP_ADD_RRR:   aluResult = valB + valC;
      `OP_ADD_RRC:   aluResult = valB + dataWord;
      `OP_SUB_RRR:   aluResult = valB - valC;
      `OP_SHL_RRR:   aluResult = valB << valC;     // Full rC as amount
      `OP_SHR_RRR:   aluResult = valB >> valC;     // Logical
      `OP_CMPLT_RRR: aluResult = cpuWord'(valB < valC);
      `OP_CMPE_RRR:  aluResult = cpuWord'(valB == valC);
      default:       doWrite = 1'b0;               // ST, jumps, STALL, no-ops
    endcase
  end

  // Branch decision on the latched rC
  always_comb begin
    case (op)
      `OP_JMP_C: takeJump = 1'b1;
      `OP_JZ_RC:  takeJump = (valC == '0);
      `OP_JNZ_RC: takeJump = (valC != '0);
      default:    takeJump = 1'b0;
    endcase
  end

  assign nextIp = takeJump ? dataWord : ipointer + (isLong ? `CPU_LONG_LEN : `CPU_SHORT_LEN);

  // Sequencer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= seqFetch;
      fetchBusy  <= 1'b0;
      fetchStart <= 1'b0;
      lsStart    <= 1'b0;
      ipointer   <= '0;
    end else begin
      fetchStart <= 1'b0;   // Pulses
      lsStart    <= 1'b0;
      case (state)
        seqFetch: begin
          if (!fetchBusy) begin
            fetchStart <= 1'b1;
            fetchBusy  <= 1'b1;
          end
          if (fetchDone) begin
            fetchBusy <= 1'b0;
            state     <= seqDecode;
          end
        end
        seqDecode: begin
          if (isMem) begin
            lsStart <= 1'b1;          // Operands are latched by then
            state   <= seqMemory;
          end else begin
            state <= seqWriteback;
          end
        end
        seqMemory: begin
          if (lsDone) state <= seqWriteback;
        end
        seqWriteback: begin
          if (op == `OP_STALL) begin
            state <= seqHalted;       // ipointer stays on the STALL
          end else begin
            ipointer <= nextIp;       // Once per instruction
            state    <= seqFetch;
          end
        end
        default: state <= seqHalted;  // Parked until reset
      endcase
    end
  end

  // Operand read
  always_ff @(posedge clk) begin
    if (state == seqDecode) begin
      valA <= regFile[rA];
      valB <= regFile[rB];
      valC <= regFile[rC];
    end
  end

  // Register file, one write port
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regFile[i] <= '0;
      end
    end else if (state == seqWriteback && doWrite) begin
      regFile[rA] <= aluResult;
    end
  end

endmodule

//--- core/instrFetch.sv
`include "cpu_consts.svh"

module instrFetch import cpuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   fetchStart,
  input  cpuAddr fetchAddr,
  input  logic   needLong,    // Sampled while instrReady is high
  output logic   instrReady,
  output logic   fetchDone,
  output cpuWord instrWord,
  output cpuWord dataWord,
  // Arbiter side
  output logic   fReq,
  output cpuAddr fAddr,
  input  logic   fDone,
  input  cpuWord fRdata
);

  typedef enum logic [1:0] {fetchIdle, fetchInstr, fetchCheck, fetchData} fetchState;

  fetchState state;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= fetchIdle;
      fReq       <= 1'b0;
      instrReady <= 1'b0;
      fetchDone  <= 1'b0;
    end else begin
      instrReady <= 1'b0;   // Pulses
      fetchDone  <= 1'b0;
      case (state)
        fetchIdle: begin
          if (fetchStart) begin
            fReq  <= 1'b1;
            state <= fetchInstr;
          end
        end
        fetchInstr: begin
          if (fDone) begin
            fReq       <= 1'b0;
            instrReady <= 1'b1;     // execUnit answers with needLong next cycle
            state      <= fetchCheck;
          end
        end
        fetchCheck: begin
          if (needLong) begin
            fReq  <= 1'b1;          // Second word of a long instruction
            state <= fetchData;
          end else begin
            fetchDone <= 1'b1;
            state     <= fetchIdle;
          end
        end
        fetchData: begin
          if (fDone) begin
            fReq      <= 1'b0;
            fetchDone <= 1'b1;
            state     <= fetchIdle;
          end
        end
        default: state <= fetchIdle;
      endcase
    end
  end

  // Address and fetched words, held until the next fetch
  always_ff @(posedge clk) begin
    if (state == fetchIdle && fetchStart) fAddr <= fetchAddr;
    if (state == fetchCheck && needLong) fAddr <= fAddr + `CPU_SHORT_LEN;
    if (state == fetchInstr && fDone) instrWord <= fRdata;
    if (state == fetchData && fDone) dataWord <= fRdata;
  end

endmodule

//--- core/loadStore.sv
module loadStore import cpuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   lsStart,
  input  logic   lsWrite,
  input  cpuWord baseValue,
  input  cpuWord offsetValue,
  input  cpuWord storeValue,
  output logic   lsDone,
  output cpuWord loadValue,
  // Arbiter side
  output logic   lsReq,
  output logic   lsWriteBus,
  output cpuAddr lsAddr,
  output cpuWord lsWdata,
  input  logic   lsDoneBus,
  input  cpuWord lsRdata
);

  logic accept;   // New request taken this cycle

  assign accept = lsStart && !lsReq;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lsReq  <= 1'b0;
      lsDone <= 1'b0;
    end else begin
      lsDone <= 1'b0;
      if (accept) begin
        lsReq <= 1'b1;        // Held until the bus finishes
      end else if (lsDoneBus) begin
        lsReq  <= 1'b0;
        lsDone <= 1'b1;
      end
    end
  end

  // Request payload and captured load data
  always_ff @(posedge clk) begin
    if (accept) begin
      lsAddr     <= baseValue + offsetValue;   // Base register plus constant
      lsWriteBus <= lsWrite;
      lsWdata    <= storeValue;
    end
    if (lsDoneBus && !lsWriteBus) begin
      loadValue <= lsRdata;                  // Valid with the done pulse
    end
  end

endmodule

//--- sources.f
+incdir+common
common/cpuPkg.sv
verilog/busArbiter.sv
core/instrFetch.sv
core/loadStore.sv
core/execUnit.sv
verilog/phaethonCpu.sv
verification/cpuTb_assert.sv
verification/cpuTb.sv

//--- verification/cpuTb.sv
`include "cpu_consts.svh"

module cpuTb import cpuPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic clk, reset, arvalid, arready, rvalid, rready, awvalid, awready;
  logic wvalid, wready, bvalid, bready, halted;
  logic [1:0] rresp, bresp;
  logic [3:0] wstrb;
  cpuAddr araddr, awaddr, ipointer, pc, expIp, seenAddr;
  cpuWord rdata, wdata, seenData, rngState;
  cpuWord mem [1024];       // 4 KB word memory
  cpuWord refMem [1024];
  cpuWord refReg [`CPU_NUM_REGS];
  cpuAddr expAddr [$];      // Expected stores in order
  cpuWord expData [$];
  logic haveAddr, haveData, pressureOn;
  int cycles, limit;

  phaethonCpu uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  function automatic logic [9:0] wordIdx(cpuAddr a);
    return a[11:2];
  endfunction

  function automatic cpuWord nextRand();   // xorshift32
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic int randDelay();
    cpuWord r;
    r = nextRand();
    return pressureOn ? int'(r % 3) : 0;
  endfunction

  // Random register field with junk in the high nibble
  function automatic logic [7:0] randField(int span);
    cpuWord r;
    r = nextRand();
    return {r[7:4], 4'(r[15:8] % span)};
  endfunction

  // ISA model running refMem from address 0 until STALL
  function automatic int refRun();
    cpuAddr ip, ea;
    cpuWord iw, dw, vb, vc, res;
    opCode op;
    regIndex a;
    logic wr, jump, done;
    int n;
    ip = '0;
    n = 0;
    done = 1'b0;
    foreach (refReg[i]) refReg[i] = '0;
    expAddr.delete();
    expData.delete();
    while (!done && n < 4000) begin
      iw = refMem[wordIdx(ip)];
      dw = refMem[wordIdx(ip + 4)];
      op = iw[7:0];
      a  = iw[11:8];                  // Low 4 bits select
      vb = refReg[iw[19:16]];
      vc = refReg[iw[27:24]];
      wr = op inside {`OP_MOV_RC, `OP_MOV_RR, `OP_LD_RRO, `OP_ADD_RRR, `OP_ADD_RRC,
                      `OP_SUB_RRR, `OP_SHL_RRR, `OP_SHR_RRR, `OP_CMPLT_RRR, `OP_CMPE_RRR};
      jump = 1'b0;
      res = '0;
      n++;
      case (op)
        `OP_MOV_RC:    res = dw;
        `OP_MOV_RR:    res = vb;
        `OP_LD_RRO:    res = refMem[wordIdx(vb + dw)];
        `OP_ST_RRO: begin
          ea = refReg[a] + dw;
          refMem[wordIdx(ea)] = vb;
          expAddr.push_back(ea);
          expData.push_back(vb);
        end
        `OP_ADD_RRR:   res = vb + vc;
        `OP_ADD_RRC:   res = vb + dw;
        `OP_SUB_RRR:   res = vb - vc;
        `OP_SHL_RRR:   res = vb << vc;
        `OP_SHR_RRR:   res = vb >> vc;
        `OP_CMPLT_RRR: res = (vb < vc) ? 32'd1 : 32'd0;
        `OP_CMPE_RRR:  res = (vb == vc) ? 32'd1 : 32'd0;
        `OP_JMP_C:     jump = 1'b1;
        `OP_JZ_RC:     jump = (vc == '0);
        `OP_JNZ_RC:    jump = (vc != '0);
        `OP_STALL:     done = 1'b1;
        default:       ;                // Unknown opcode acts as a 4-byte no-op
      endcase
      if (done) begin
        expIp = ip;
      end else begin
        if (wr) refReg[a] = res;
        if (jump) ip = dw;
        else if (op inside {`OP_MOV_RC, `OP_LD_RRO, `OP_ST_RRO, `OP_ADD_RRC,
                            `OP_JMP_C, `OP_JZ_RC, `OP_JNZ_RC}) ip = ip + 8;
        else ip = ip + 4;
      end
    end
    return n;
  endfunction

  task automatic reportFail(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped on first error");
  endtask

  task automatic checkStoreAddr(cpuAddr got, cpuAddr exp);
    if (got !== exp) reportFail($sformatf("[FAIL] %0t store address %h, expected %h",
                                          $time, got, exp));
  endtask

  task automatic checkStoreData(cpuWord got, cpuWord exp);
    if (got !== exp) reportFail($sformatf("[FAIL] %0t store data %h, expected %h",
                                          $time, got, exp));
  endtask

  task automatic checkStrobe(logic [3:0] got, logic [3:0] exp);
    if (got !== exp) reportFail($sformatf("[FAIL] %0t write strobe %b, expected %b",
                                          $time, got, exp));
  endtask

  task automatic checkIpointer(cpuAddr got, cpuAddr exp);
    if (got !== exp) reportFail($sformatf("[FAIL] %0t final ipointer %h, expected %h",
                                          $time, got, exp));
  endtask

  // Memory image helpers
  task automatic clearMem();
    foreach (mem[i]) mem[i] = (cpuWord'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    pc = '0;
  endtask

  task automatic emitShort(opCode op, logic [7:0] a, logic [7:0] b, logic [7:0] c);
    mem[wordIdx(pc)] = {c, b, a, op};
    pc = pc + 4;
  endtask

  task automatic emitLong(opCode op, logic [7:0] a, logic [7:0] b, logic [7:0] c, cpuWord d);
    emitShort(op, a, b, c);
    mem[wordIdx(pc)] = d;
    pc = pc + 4;
  endtask

  task automatic loadArith();
    logic [7:0] res [7] = '{3, 4, 6, 7, 8, 9, 10};
    clearMem();
    emitLong(`OP_MOV_RC, 1, 0, 0, 100);
    emitLong(`OP_MOV_RC, 2, 0, 0, 7);
    emitLong(`OP_MOV_RC, 5, 0, 0, 3);
    emitLong(`OP_MOV_RC, 0, 0, 0, 32'h800);
    emitShort(`OP_ADD_RRR, 8'hF3, 1, 2);       // High nibble ignored
    emitShort(`OP_SUB_RRR, 4, 1, 2);
    emitShort(`OP_SHL_RRR, 6, 1, 5);
    emitShort(`OP_SHR_RRR, 7, 1, 5);
    emitShort(`OP_CMPLT_RRR, 8, 2, 1);
    emitShort(`OP_CMPE_RRR, 9, 1, 2);
    emitLong(`OP_ADD_RRC, 10, 1, 0, 32'h1000);
    foreach (res[i]) emitLong(`OP_ST_RRO, 0, res[i], 0, cpuWord'(i * 4));
    emitShort(`OP_STALL, 0, 0, 0);
  endtask

  task automatic loadMemOps();
    clearMem();
    mem[wordIdx(32'h900)] = 32'h1234_5678;
    mem[wordIdx(32'h904)] = 32'h0000_1111;
    emitLong(`OP_MOV_RC, 1, 0, 0, 32'h900);
    emitLong(`OP_LD_RRO, 2, 1, 0, 0);
    emitLong(`OP_LD_RRO, 3, 1, 0, 4);
    emitShort(`OP_ADD_RRR, 4, 2, 3);
    emitLong(`OP_ST_RRO, 1, 4, 0, 32'h10);
    emitShort(`OP_MOV_RR, 5, 3, 0);
    emitShort(`OP_SUB_RRR, 6, 5, 2);
    emitLong(`OP_ST_RRO, 1, 6, 0, 32'h14);
    emitShort(`OP_STALL, 0, 0, 0);
  endtask

  task automatic loadLoop();
    cpuAddr loopTop;
    clearMem();
    emitLong(`OP_MOV_RC, 1, 0, 0, 5);           // Counter
    emitLong(`OP_MOV_RC, 2, 0, 0, 1);
    emitLong(`OP_MOV_RC, 0, 0, 0, 32'h800);
    loopTop = pc;
    emitLong(`OP_ST_RRO, 0, 1, 0, 0);
    emitLong(`OP_ADD_RRC, 0, 0, 0, 4);
    emitShort(`OP_SUB_RRR, 1, 1, 2);
    emitLong(`OP_JNZ_RC, 0, 0, 1, loopTop);
    emitLong(`OP_JZ_RC, 0, 0, 1, pc + 16);     // Skips the next store
    emitLong(`OP_ST_RRO, 0, 2, 0, 32'h40);
    emitLong(`OP_JMP_C, 0, 0, 0, pc + 12);     // Skips an early STALL
    emitShort(`OP_STALL, 0, 0, 0);
    emitShort(8'h77, 0, 0, 0);                  // Unknown opcode
    emitLong(`OP_ST_RRO, 0, 1, 0, 0);
    emitShort(`OP_STALL, 0, 0, 0);
  endtask

  task automatic loadRandom();
    opCode aluOps [7] = '{`OP_MOV_RR, `OP_ADD_RRR, `OP_SUB_RRR, `OP_SHL_RRR,
                          `OP_SHR_RRR, `OP_CMPLT_RRR, `OP_CMPE_RRR};
    cpuWord kind;
    clearMem();
    emitLong(`OP_MOV_RC, 15, 0, 0, 32'h800);    // r15 is the data base
    for (int r = 0; r < 15; r++) emitLong(`OP_MOV_RC, 8'(r), 0, 0, nextRand());
    for (int k = 0; k < 25; k++) begin
      kind = nextRand() % 10;
      if (kind < 7) emitShort(aluOps[kind], randField(15), randField(16), randField(16));
      else if (kind == 7) emitLong(`OP_LD_RRO, randField(15), 8'h0F, 0, (nextRand() % 128) * 4);
      else if (kind == 8) emitLong(`OP_ST_RRO, 8'h0F, randField(16), 0, (nextRand() % 128) * 4);
      else emitLong(`OP_ADD_RRC, randField(15), randField(16), 0, nextRand());
    end
    emitShort(`OP_STALL, 0, 0, 0);
  endtask

  task automatic runProgram(logic pressure);
    foreach (mem[i]) refMem[i] = mem[i];
    limit = limit + refRun() * 40 + 60;        // Reset and halt check included
    pressureOn = pressure;
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    while (!halted) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      if (arvalid || awvalid) reportFail("Bus transaction started after the CPU halted");
      if (!halted) reportFail("Halted output dropped without a reset");
    end
    checkIpointer(ipointer, expIp);
    if (expAddr.size() != 0) reportFail("CPU halted before making all expected stores");
    foreach (mem[i]) checkStoreData(mem[i], refMem[i]);   // Final memory image
  endtask

  // Steps to 1 ns after the n-th next rising edge
  task automatic waitCycles(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // AXI4-Lite slave serving one transaction at a time
  task automatic serveRead();
    cpuAddr addr;
    addr = araddr;
    waitCycles(randDelay());
    arready = 1'b1;
    waitCycles(1);
    arready = 1'b0;
    waitCycles(randDelay());
    rdata = mem[wordIdx(addr)];
    rvalid = 1'b1;
    while (!rready) waitCycles(1);
    waitCycles(1);                      // Handshake edge
    rvalid = 1'b0;
  endtask

  task automatic serveWrite();
    cpuAddr addr;
    cpuWord data;
    addr = awaddr;
    data = wdata;
    waitCycles(randDelay());
    awready = 1'b1;
    wready = 1'b1;
    waitCycles(1);
    awready = 1'b0;
    wready = 1'b0;
    mem[wordIdx(addr)] = data;
    waitCycles(randDelay());
    bvalid = 1'b1;
    while (!bready) waitCycles(1);
    waitCycles(1);                      // Handshake edge
    bvalid = 1'b0;
  endtask

  initial begin
    forever begin
      waitCycles(1);
      if (!reset && arvalid) serveRead();
      else if (!reset && awvalid) serveWrite();
    end
  end

  // Store compare against the reference order
  always @(negedge clk) begin
    if (!reset) begin
      if (awvalid && awready) begin
        seenAddr = awaddr;
        haveAddr = 1'b1;
      end
      if (wvalid && wready) begin
        seenData = wdata;
        haveData = 1'b1;
        checkStrobe(wstrb, 4'b1111);    // Whole-word writes only
      end
      if (haveAddr && haveData) begin
        haveAddr = 1'b0;
        haveData = 1'b0;
        if (expAddr.size() == 0) reportFail("CPU made a store the reference does not make");
        else begin
          checkStoreAddr(seenAddr, expAddr.pop_front());
          checkStoreData(seenData, expData.pop_front());
        end
      end
    end
  end

  always @(posedge clk) begin   // Watchdog
    cycles++;
    if (cycles > limit) reportFail($sformatf("Timeout after %0d cycles", cycles));
  end

  initial begin
    reset = 1'b1;
    {arready, rvalid, awready, wready, bvalid} = '0;
    rdata = '0;
    rresp = 2'b00;
    bresp = 2'b00;
    rngState = 32'd86676;
    {haveAddr, haveData, pressureOn} = '0;
    cycles = 0;
    limit = 0;
    for (int p = 0; p < 2; p++) begin          // Plain pass first and back-pressure second
      loadArith();
      runProgram(p[0]);
      loadMemOps();
      runProgram(p[0]);
      loadLoop();
      runProgram(p[0]);
    end
    repeat (3) begin
      loadRandom();
      runProgram(1'b1);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- verification/cpuTb_assert.sv
module cpuTb_assert import cpuPkg::*; (
  input logic   clk,
  input logic   reset,
  input logic   arvalid,
  input logic   arready,
  input cpuAddr araddr,
  input logic   awvalid,
  input logic   awready,
  input cpuAddr awaddr,
  input logic   wvalid,
  input logic   wready,
  input cpuWord wdata
);
  timeunit 1ns;
  timeprecision 100ps;

  // Valid held with stable payload until accepted
  arHold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr)) else $error("arvalid dropped early");
  awHold: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr)) else $error("awvalid dropped early");
  wHold: assert property (@(posedge clk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata)) else $error("wvalid dropped early");
  // One transaction at a time
  oneChannel: assert property (@(posedge clk) disable iff (reset)
    !(arvalid && awvalid)) else $error("read and write address valid together");
endmodule

bind busArbiter cpuTb_assert arbProps (
  .clk(clk), .reset(reset), .arvalid(arvalid), .arready(arready), .araddr(araddr),
  .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
  .wvalid(wvalid), .wready(wready), .wdata(wdata)
);

//--- verilog/busArbiter.sv
module busArbiter import cpuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  // Instruction fetch requester, read only
  input  logic       fReq,
  input  cpuAddr     fAddr,
  output logic       fDone,
  output cpuWord     fRdata,
  // Load/store requester
  input  logic       lsReq,
  input  logic       lsWrite,
  input  cpuAddr     lsAddr,
  input  cpuWord     lsWdata,
  output logic       lsDoneBus,
  output cpuWord     lsRdata,
  // AXI4-Lite master
  output cpuAddr     araddr,
  output logic       arvalid,
  input  logic       arready,
  input  cpuWord     rdata,
  input  logic [1:0] rresp,    // Not acted on, data taken as is
  input  logic       rvalid,
  output logic       rready,
  output cpuAddr     awaddr,
  output logic       awvalid,
  input  logic       awready,
  output cpuWord     wdata,
  output logic [3:0] wstrb,
  output logic       wvalid,
  input  logic       wready,
  input  logic [1:0] bresp,    // Not acted on either
  input  logic       bvalid,
  output logic       bready
);

  typedef enum logic [1:0] {arbIdle, arbRead, arbWrite} arbState;

  arbState state;
  logic    grantLs;    // Owner of the transaction in flight
  logic    readDone;
  logic    writeDone;

  assign rready    = (state == arbRead);   // Ready for the response as soon as we ask
  assign bready    = (state == arbWrite);
  assign wstrb     = 4'b1111;              // Whole words only
  assign readDone  = rready && rvalid;
  assign writeDone = bready && bvalid;

  // Done pulses go back in the handshake cycle, read data with them
  assign fDone     = readDone && !grantLs;
  assign lsDoneBus = (readDone || writeDone) && grantLs;
  assign fRdata    = rdata;
  assign lsRdata   = rdata;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= arbIdle;
      grantLs <= 1'b0;
      arvalid <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      case (state)
        arbIdle: begin
          if (lsReq) begin                 // Data side wins a tie
            grantLs <= 1'b1;
            if (lsWrite) begin
              awvalid <= 1'b1;             // Address and data go out together
              wvalid  <= 1'b1;
              state   <= arbWrite;
            end else begin
              arvalid <= 1'b1;
              state   <= arbRead;
            end
          end else if (fReq) begin
            grantLs <= 1'b0;
            arvalid <= 1'b1;
            state   <= arbRead;
          end
        end
        arbRead: begin
          if (arready) arvalid <= 1'b0;
          if (readDone) state <= arbIdle;
        end
        arbWrite: begin
          if (awready) awvalid <= 1'b0;    // Channels may accept in either order
          if (wready) wvalid <= 1'b0;
          if (writeDone) state <= arbIdle;
        end
        default: state <= arbIdle;
      endcase
    end
  end

  // Payload tracks the requesters while idle and freezes once a valid rises
  always_ff @(posedge clk) begin
    if (state == arbIdle) begin
      araddr <= lsReq ? lsAddr : fAddr;
      awaddr <= lsAddr;
      wdata  <= lsWdata;
    end
  end

endmodule

//--- verilog/phaethonCpu.sv
module phaethonCpu import cpuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  output cpuAddr     araddr,
  output logic       arvalid,
  input  logic       arready,
  input  cpuWord     rdata,
  input  logic [1:0] rresp,
  input  logic       rvalid,
  output logic       rready,
  output cpuAddr     awaddr,
  output logic       awvalid,
  input  logic       awready,
  output cpuWord     wdata,
  output logic [3:0] wstrb,
  output logic       wvalid,
  input  logic       wready,
  input  logic [1:0] bresp,
  input  logic       bvalid,
  output logic       bready,
  output logic       halted,
  output cpuAddr     ipointer
);

  // Sequencer to fetch
  logic   fetchStart;
  logic   needLong;
  logic   instrReady;
  logic   fetchDone;
  cpuAddr fetchAddr;
  cpuWord instrWord;
  cpuWord dataWord;
  // Sequencer to load/store
  logic   lsStart;
  logic   lsWrite;
  logic   lsDone;
  cpuWord baseValue;
  cpuWord offsetValue;
  cpuWord storeValue;
  cpuWord loadValue;
  // Requesters to arbiter
  logic   fReq;
  logic   fDone;
  cpuAddr fAddr;
  cpuWord fRdata;
  logic   lsReq;
  logic   lsWriteBus;
  logic   lsDoneBus;
  cpuAddr lsAddr;
  cpuWord lsWdata;
  cpuWord lsRdata;

  execUnit exec (
    .clk, .reset, .halted, .ipointer,
    .fetchStart, .fetchAddr, .needLong, .instrReady, .fetchDone, .instrWord, .dataWord,
    .lsStart, .lsWrite, .baseValue, .offsetValue, .storeValue, .lsDone, .loadValue
  );

  instrFetch fetch (
    .clk, .reset, .fetchStart, .fetchAddr, .needLong,
    .instrReady, .fetchDone, .instrWord, .dataWord,
    .fReq, .fAddr, .fDone, .fRdata
  );

  loadStore lsu (
    .clk, .reset, .lsStart, .lsWrite, .baseValue, .offsetValue, .storeValue,
    .lsDone, .loadValue,
    .lsReq, .lsWriteBus, .lsAddr, .lsWdata, .lsDoneBus, .lsRdata
  );

  busArbiter arb (
    .clk, .reset,
    .fReq, .fAddr, .fDone, .fRdata,
    .lsReq, .lsWrite(lsWriteBus), .lsAddr, .lsWdata, .lsDoneBus, .lsRdata,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

endmodule
